// ==== hdl/rvv_pkg.sv ====
package rvv_pkg;

	// register file geometry
	localparam int VLEN          = 128;
	localparam int NREGS         = 32;
	localparam int ELEM_W        = 32;                // memory element width
	localparam int ELEMS_PER_REG = VLEN / ELEM_W;
	localparam int REG_IDX_W     = 5;
	localparam int VL_W          = 32;                // vl and vtype width

	localparam logic [VL_W-1:0] VTYPE_VILL = 32'h8000_0000; // only vill set

	// major opcodes
	localparam logic [6:0] OPC_VEC_CFG = 7'b1010111;
	localparam logic [6:0] OPC_VLOAD   = 7'b0000111;
	localparam logic [6:0] OPC_VSTORE  = 7'b0100111;

	localparam logic [2:0] FUNCT3_CFG = 3'b111;       // OPCFG
	localparam logic [2:0] WIDTH_E32  = 3'b110;       // 32-bit elements

	// decoded operations
	typedef enum logic [2:0] {
		OP_NONE,
		OP_VSETVLI,
		OP_VSETIVLI,
		OP_VSETVL,
		OP_VLE32,
		OP_VSE32
	} rvv_op_e;

	typedef logic [VLEN-1:0] vreg_t;

endpackage

// ==== hdl/rvv_decode.sv ====
`timescale 1ns/1ps

module rvv_decode import rvv_pkg::*; (
	input  logic [31:0] insn_i,
	output rvv_op_e     op_o,
	output logic        is_rvv_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;   // width field for loads and stores
	logic [2:0] nf;
	logic       mew;
	logic [1:0] mop;
	logic       vm;
	logic [4:0] umop;     // lumop / sumop
	logic       unit_e32;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];
	assign nf     = insn_i[31:29];
	assign mew    = insn_i[28];
	assign mop    = insn_i[27:26];
	assign vm     = insn_i[25];
	assign umop   = insn_i[24:20];

	// unit-stride, unmasked, single field, 32-bit elements
	assign unit_e32 = funct3 == WIDTH_E32 && nf == 3'd0 && !mew && mop == 2'b00 &&
		vm && umop == 5'd0;

	always_comb begin
		op_o = OP_NONE;
		if (opcode == OPC_VEC_CFG && funct3 == FUNCT3_CFG) begin
			if (!insn_i[31])
				op_o = OP_VSETVLI;
			else if (insn_i[30])
				op_o = OP_VSETIVLI;
			else if (insn_i[30:25] == 6'b000000)
				op_o = OP_VSETVL;    // bits 31:25 = 1000000
		end else if (opcode == OPC_VLOAD && unit_e32) begin
			op_o = OP_VLE32;
		end else if (opcode == OPC_VSTORE && unit_e32) begin
			op_o = OP_VSE32;
		end
	end

	assign is_rvv_o = op_o != OP_NONE;

endmodule

// ==== hdl/rvv_vcfg.sv ====
`timescale 1ns/1ps

module rvv_vcfg import rvv_pkg::*; (
	input  logic            clk,
	input  logic            resetn,
	input  logic            run_i,
	input  rvv_op_e         op_i,
	input  logic [31:0]     insn_i,
	input  logic [31:0]     rs1_i,
	input  logic [31:0]     rs2_i,
	output logic [VL_W-1:0] vl_o,
	output logic            cfg_ready_o,
	output logic [VL_W-1:0] cfg_rd_o
);

	logic [VL_W-1:0] vl_q;
	logic [VL_W-1:0] vtype_q;
	logic [VL_W-1:0] new_vtype;
	logic [VL_W-1:0] avl;
	logic [VL_W-1:0] vlmax;
	logic [VL_W-1:0] new_vl;
	logic [2:0]      sew;
	logic [2:0]      lmul;
	logic            legal;
	logic            is_cfg;

	assign is_cfg = op_i inside {OP_VSETVLI, OP_VSETIVLI, OP_VSETVL};

	// vma, vta, vsew, vlmul from the immediate, whole rs2 for vsetvl
	assign new_vtype = (op_i == OP_VSETVL) ? rs2_i : VL_W'(insn_i[27:20]);
	assign sew  = new_vtype[5:3];
	assign lmul = new_vtype[2:0];

	// e8..e32 with integer lmul only
	assign legal = !new_vtype[31] && new_vtype[30:8] == '0 && sew <= 3'd2 && !lmul[2];
	assign vlmax = legal ? (VL_W'(VLEN) >> (sew + 3'd3)) << lmul[1:0] : '0;

	always_comb begin
		if (op_i == OP_VSETIVLI)
			avl = VL_W'(insn_i[19:15]);    // uimm5
		else if (insn_i[19:15] != 5'd0)
			avl = rs1_i;
		else if (insn_i[11:7] != 5'd0)
			avl = '1;                      // rs1=x0, rd!=x0 asks for vlmax
		else
			avl = vl_q;                    // keep vl
	end

	assign new_vl = (avl < vlmax) ? avl : vlmax;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vl_q        <= '0;
			vtype_q     <= VTYPE_VILL;
			cfg_ready_o <= 1'b0;
		end else begin
			cfg_ready_o <= run_i && is_cfg;
			if (run_i && is_cfg) begin
				vl_q    <= new_vl;
				vtype_q <= legal ? new_vtype : VTYPE_VILL;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (run_i && is_cfg)
			cfg_rd_o <= new_vl;
	end

	assign vl_o = vl_q;

	// e8 with m8 is the largest group
	assert property (@(posedge clk) disable iff (!resetn) vl_q <= VL_W'(VLEN));
	// the top drops run while ready is up
	assert property (@(posedge clk) disable iff (!resetn) cfg_ready_o |=> !cfg_ready_o);
	assert property (@(posedge clk) disable iff (!resetn) vtype_q[31] |-> vl_q == '0);

endmodule

// ==== hdl/rvv_mem_seq.sv ====
`timescale 1ns/1ps

module rvv_mem_seq import rvv_pkg::*; (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  run_i,
	input  rvv_op_e               op_i,
	input  logic [31:0]           insn_i,
	input  logic [31:0]           rs1_i,
	input  logic [VL_W-1:0]       vl_i,
	output logic                  mem_valid_o,
	output logic                  mem_write_o,
	output logic [31:0]           mem_addr_o,
	output logic [ELEM_W-1:0]     mem_wdata_o,
	output logic [ELEM_W/8-1:0]   mem_strb_o,
	input  logic [ELEM_W-1:0]     mem_rdata_i,
	input  logic                  mem_done_i,
	output logic                  mem_ready_o,
	output logic                  busy_o,
	output logic [REG_IDX_W-1:0]  vreg_addr_o,
	output logic                  vreg_wen_o,
	output vreg_t                 vreg_wdata_o,
	input  vreg_t                 vreg_rdata_i
);

	// REQ holds a transfer, DONE is the gap after it
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		DONE
	} state_e;

	state_e                             state_q;
	logic [VL_W-1:0]                    cnt_q;     // element index
	logic                               store_q;
	logic                               start;
	logic                               last;
	logic [REG_IDX_W-1:0]               reg_idx;
	logic [$clog2(ELEMS_PER_REG)-1:0]   slot;
	logic [ELEM_W-1:0]                  slot_data;

	assign start = run_i && (op_i == OP_VLE32 || op_i == OP_VSE32);
	assign last  = cnt_q == vl_i;   // every element moved

	assign reg_idx = REG_IDX_W'(cnt_q / ELEMS_PER_REG);
	assign slot    = cnt_q[$clog2(ELEMS_PER_REG)-1:0];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= IDLE;
			cnt_q   <= '0;
			store_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start) begin
						cnt_q   <= '0;
						store_q <= op_i == OP_VSE32;
						state_q <= (vl_i == '0) ? DONE : REQ;
					end
				end
				REQ: begin
					if (mem_done_i) begin
						cnt_q   <= cnt_q + 1'b1;
						state_q <= DONE;
					end
				end
				DONE: begin
					state_q <= last ? IDLE : REQ;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// vd / vs3 plus group offset, wraps past v31
	assign vreg_addr_o = insn_i[11:7] + reg_idx;
	assign slot_data   = vreg_rdata_i[slot*ELEM_W +: ELEM_W];

	// load merges the word into the current register
	always_comb begin
		vreg_wdata_o = vreg_rdata_i;
		vreg_wdata_o[slot*ELEM_W +: ELEM_W] = mem_rdata_i;
	end
	assign vreg_wen_o = state_q == REQ && mem_done_i && !store_q;

	assign mem_valid_o = state_q == REQ;
	assign mem_write_o = store_q;
	assign mem_addr_o  = rs1_i + (cnt_q << $clog2(ELEM_W/8)); // unit stride
	assign mem_wdata_o = store_q ? slot_data : '0;
	assign mem_strb_o  = {(ELEM_W/8){store_q}};

	assign mem_ready_o = state_q == DONE && last;
	assign busy_o      = (state_q == IDLE && start) || state_q == REQ ||
		(state_q == DONE && !last);

	// request held until the memory side answers
	assert property (@(posedge clk) disable iff (!resetn)
		mem_valid_o && !mem_done_i |=> mem_valid_o && $stable(mem_addr_o) &&
			$stable(mem_wdata_o) && $stable(mem_write_o));
	assert property (@(posedge clk) disable iff (!resetn)
		mem_valid_o && mem_done_i |=> !mem_valid_o);

endmodule

// ==== hdl/rvv_vregs.sv ====
`timescale 1ns/1ps

module rvv_vregs import rvv_pkg::*; (
	input  logic                 clk,
	input  logic                 wen_i,
	input  logic [REG_IDX_W-1:0] waddr_i,
	input  vreg_t                wdata_i,
	input  logic [REG_IDX_W-1:0] raddr_i,
	output vreg_t                rdata_o
);

	vreg_t regs [NREGS];

	always_ff @(posedge clk) begin
		if (wen_i)
			regs[waddr_i] <= wdata_i;
	end

	assign rdata_o = regs[raddr_i];   // async read

endmodule

// ==== hdl/rvv_coproc.sv ====
`timescale 1ns/1ps

module rvv_coproc import rvv_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        pcpi_valid_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  logic [31:0] pcpi_rs2_i,
	output logic        pcpi_wr_o,
	output logic [31:0] pcpi_rd_o,
	output logic        pcpi_wait_o,
	output logic        pcpi_ready_o,
	output logic        pcpi_is_rvv_insn_o,
	output logic        mem_valid_o,
	output logic        mem_write_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0]  mem_strb_o,
	input  logic [31:0] mem_rdata_i,
	input  logic        mem_done_i
);

	rvv_op_e              op;
	logic                 run;
	logic [VL_W-1:0]      vl;
	logic                 cfg_ready;
	logic [VL_W-1:0]      cfg_rd;
	logic                 mem_ready;
	logic [REG_IDX_W-1:0] vreg_addr;
	logic                 vreg_wen;
	vreg_t                vreg_wdata;
	vreg_t                vreg_rdata;

	// nothing runs in the ready cycle
	assign run = pcpi_valid_i && !pcpi_ready_o && op != OP_NONE;

	assign pcpi_ready_o = cfg_ready | mem_ready;
	assign pcpi_wr_o    = cfg_ready;
	assign pcpi_rd_o    = cfg_ready ? cfg_rd : '0;

	rvv_decode u_decode (
		.insn_i   (pcpi_insn_i),
		.op_o     (op),
		.is_rvv_o (pcpi_is_rvv_insn_o)
	);

	rvv_vcfg u_vcfg (
		.clk         (clk),
		.resetn      (resetn),
		.run_i       (run),
		.op_i        (op),
		.insn_i      (pcpi_insn_i),
		.rs1_i       (pcpi_rs1_i),
		.rs2_i       (pcpi_rs2_i),
		.vl_o        (vl),
		.cfg_ready_o (cfg_ready),
		.cfg_rd_o    (cfg_rd)
	);

	rvv_mem_seq u_mem_seq (
		.clk          (clk),
		.resetn       (resetn),
		.run_i        (run),
		.op_i         (op),
		.insn_i       (pcpi_insn_i),
		.rs1_i        (pcpi_rs1_i),
		.vl_i         (vl),
		.mem_valid_o  (mem_valid_o),
		.mem_write_o  (mem_write_o),
		.mem_addr_o   (mem_addr_o),
		.mem_wdata_o  (mem_wdata_o),
		.mem_strb_o   (mem_strb_o),
		.mem_rdata_i  (mem_rdata_i),
		.mem_done_i   (mem_done_i),
		.mem_ready_o  (mem_ready),
		.busy_o       (pcpi_wait_o),
		.vreg_addr_o  (vreg_addr),
		.vreg_wen_o   (vreg_wen),
		.vreg_wdata_o (vreg_wdata),
		.vreg_rdata_i (vreg_rdata)
	);

	// one address serves both read and write
	rvv_vregs u_vregs (
		.clk     (clk),
		.wen_i   (vreg_wen),
		.waddr_i (vreg_addr),
		.wdata_i (vreg_wdata),
		.raddr_i (vreg_addr),
		.rdata_o (vreg_rdata)
	);

endmodule

// ==== test/rvv_checker.sv ====
`timescale 1ns/1ps

module rvv_checker import rvv_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        pcpi_valid_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  logic [31:0] pcpi_rs2_i,
	input  logic        pcpi_wr_o,
	input  logic [31:0] pcpi_rd_o,
	input  logic        pcpi_wait_o,
	input  logic        pcpi_ready_o,
	input  logic        pcpi_is_rvv_insn_o,
	input  logic        mem_valid_o,
	input  logic        mem_write_o,
	input  logic [31:0] mem_addr_o,
	input  logic [31:0] mem_wdata_o,
	input  logic [3:0]  mem_strb_o,
	input  logic [31:0] mem_rdata_i,
	input  logic        mem_done_i,
	output int          value_errs_o,
	output int          proto_errs_o
);

	int          value_errs = 0;
	int          proto_errs = 0;
	logic        first_q = 1'b0;
	logic        busy = 1'b0;
	rvv_op_e     cur_op;
	logic [31:0] cur_insn, cur_rs1;
	logic [31:0] mvl;          // model vl
	logic [31:0] exp_vl;
	int          age, xfers;
	logic [31:0] rmodel [32][4];
	logic        known  [32][4];

	assign value_errs_o = value_errs;
	assign proto_errs_o = proto_errs;

	initial begin
		for (int r = 0; r < 32; r++)
			for (int s = 0; s < 4; s++)
				known[r][s] = 1'b0;
	end

	task automatic bad_value(input string name, input logic [31:0] exp, act);
		$display("[FAIL] %s expected %h got %h", name, exp, act);
		value_errs++;
	endtask

	task automatic bad_proto(input string what);
		$display("protocol error at %0t: %s", $time, what);
		proto_errs++;
	endtask

	// field rules of the five supported encodings
	function automatic rvv_op_e classify(input logic [31:0] w);
		if (w[6:0] == 7'b1010111 && w[14:12] == 3'b111) begin
			if (w[31] == 1'b0)
				return OP_VSETVLI;
			if (w[31:30] == 2'b11)
				return OP_VSETIVLI;
			if (w[31:25] == 7'b1000000)
				return OP_VSETVL;
		end
		if (w[14:12] == 3'b110 && w[31:20] == 12'h020) begin
			if (w[6:0] == 7'b0000111)
				return OP_VLE32;
			if (w[6:0] == 7'b0100111)
				return OP_VSE32;
		end
		return OP_NONE;
	endfunction

	function automatic logic [31:0] model_vl(input rvv_op_e op, input logic [31:0] w, rs1, rs2);
		logic [31:0] vt, avl, vlmax;
		vt = (op == OP_VSETVL) ? rs2 : {24'd0, w[27:20]};
		if (vt[31:8] != 0 || vt[5:3] > 3'd2 || vt[2:0] > 3'd3)
			return 0;   // vill
		vlmax = (VLEN / (8 << vt[5:3])) * (1 << vt[2:0]);
		if (op == OP_VSETIVLI)
			avl = w[19:15];
		else if (w[19:15] != 0)
			avl = rs1;
		else if (w[11:7] != 0)
			avl = 32'hffff_ffff;
		else
			avl = mvl;
		return (avl > vlmax) ? vlmax : avl;
	endfunction

	task automatic check_transfer();
		logic [4:0] rn;
		int         sl;
		rn = 5'((cur_insn[11:7] + xfers / 4) % 32);
		sl = xfers % 4;
		if (xfers >= mvl)
			bad_proto("more memory transfers than vl");
		if (mem_addr_o !== cur_rs1 + 4 * xfers)
			bad_value("mem_addr_o", cur_rs1 + 4 * xfers, mem_addr_o);
		if (mem_write_o !== (cur_op == OP_VSE32))
			bad_value("mem_write_o", cur_op == OP_VSE32, mem_write_o);
		if (cur_op == OP_VSE32) begin
			if (mem_strb_o !== 4'hf)
				bad_value("mem_strb_o", 4'hf, mem_strb_o);
			if (known[rn][sl] && mem_wdata_o !== rmodel[rn][sl])
				bad_value("mem_wdata_o", rmodel[rn][sl], mem_wdata_o);
		end else begin
			if (mem_strb_o !== 4'h0)
				bad_value("mem_strb_o", 4'h0, mem_strb_o);
			rmodel[rn][sl] = mem_rdata_i;
			known[rn][sl]  = 1'b1;
		end
		xfers++;
	endtask

	// outputs settle from the first reset edge on
	always @(posedge clk) begin
		if (first_q) begin
			if (pcpi_ready_o !== 1'b0) bad_value("pcpi_ready_o", 0, pcpi_ready_o);
			if (pcpi_wr_o !== 1'b0) bad_value("pcpi_wr_o", 0, pcpi_wr_o);
			if (pcpi_wait_o !== 1'b0) bad_value("pcpi_wait_o", 0, pcpi_wait_o);
			if (mem_valid_o !== 1'b0) bad_value("mem_valid_o", 0, mem_valid_o);
		end
		first_q = !resetn;
		if (!resetn) begin
			mvl  = 0;
			busy = 1'b0;
		end else begin
			if (pcpi_is_rvv_insn_o !== (classify(pcpi_insn_i) != OP_NONE))
				bad_value("pcpi_is_rvv_insn_o", classify(pcpi_insn_i) != OP_NONE,
					pcpi_is_rvv_insn_o);
			if (busy) begin
				age++;
				if (mem_valid_o && (cur_op != OP_VLE32 && cur_op != OP_VSE32))
					bad_proto("memory request during a configuration instruction");
				if (mem_valid_o && mem_done_i)
					check_transfer();
				if (pcpi_ready_o) begin
					if (pcpi_wait_o) bad_proto("pcpi_wait_o high in the ready cycle");
					if (cur_op == OP_VLE32 || cur_op == OP_VSE32) begin
						if (pcpi_wr_o !== 1'b0) bad_value("pcpi_wr_o", 0, pcpi_wr_o);
						if (xfers != mvl) bad_value("transfer count", mvl, xfers);
					end else begin
						if (pcpi_wr_o !== 1'b1) bad_value("pcpi_wr_o", 1, pcpi_wr_o);
						if (pcpi_rd_o !== exp_vl) bad_value("pcpi_rd_o", exp_vl, pcpi_rd_o);
						mvl = exp_vl;
					end
					busy = 1'b0;
				end else if (cur_op == OP_VLE32 || cur_op == OP_VSE32) begin
					if (!pcpi_wait_o) bad_proto("pcpi_wait_o low during a memory instruction");
					if (age == 1 && mvl != 0 && !mem_valid_o)
						bad_proto("no memory request in the cycle after start");
					if (age == 1 && mvl == 0)
						bad_proto("no ready in the cycle after a start with vl of zero");
				end else begin
					bad_proto("configuration result not ready one cycle after start");
					busy = 1'b0;
				end
			end else if (pcpi_valid_i && classify(pcpi_insn_i) != OP_NONE) begin
				busy     = 1'b1;
				age      = 0;
				xfers    = 0;
				cur_op   = classify(pcpi_insn_i);
				cur_insn = pcpi_insn_i;
				cur_rs1  = pcpi_rs1_i;
				exp_vl   = model_vl(cur_op, pcpi_insn_i, pcpi_rs1_i, pcpi_rs2_i);
				if (pcpi_wait_o !== (cur_op == OP_VLE32 || cur_op == OP_VSE32))
					bad_proto("pcpi_wait_o wrong in the start cycle");
			end else if (pcpi_ready_o || pcpi_wait_o || mem_valid_o) begin
				bad_proto("output active with no instruction running");
			end
		end
	end

endmodule

// ==== test/tb_rvv.sv ====
`timescale 1ns/1ps

module tb_rvv import rvv_pkg::*;;

	localparam int MEM_WORDS = 1024;
	localparam int N_INSN    = 40;
	localparam int SEED      = 55208;
	localparam int MAX_VL    = 32;
	localparam int CYC_LIMIT = N_INSN * (MAX_VL * 8 + 4) + 200;

	logic        clk;
	logic        resetn;
	logic        pcpi_valid, pcpi_wr, pcpi_wait, pcpi_ready, pcpi_is_rvv;
	logic [31:0] pcpi_insn, pcpi_rs1, pcpi_rs2, pcpi_rd;
	logic        mem_valid, mem_write, mem_done;
	logic [31:0] mem_addr, mem_wdata, mem_rdata;
	logic [3:0]  mem_strb;
	int          value_errs, proto_errs;
	int          cycles;
	logic [31:0] mem [MEM_WORDS];
	logic [31:0] stim_state;
	logic [31:0] resp_state;
	int          resp_delay;
	logic        resp_busy;

	rvv_coproc UUT (
		.clk(clk), .resetn(resetn),
		.pcpi_valid_i(pcpi_valid), .pcpi_insn_i(pcpi_insn),
		.pcpi_rs1_i(pcpi_rs1), .pcpi_rs2_i(pcpi_rs2),
		.pcpi_wr_o(pcpi_wr), .pcpi_rd_o(pcpi_rd), .pcpi_wait_o(pcpi_wait),
		.pcpi_ready_o(pcpi_ready), .pcpi_is_rvv_insn_o(pcpi_is_rvv),
		.mem_valid_o(mem_valid), .mem_write_o(mem_write), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_strb_o(mem_strb),
		.mem_rdata_i(mem_rdata), .mem_done_i(mem_done)
	);

	rvv_checker u_checker (
		.clk(clk), .resetn(resetn),
		.pcpi_valid_i(pcpi_valid), .pcpi_insn_i(pcpi_insn),
		.pcpi_rs1_i(pcpi_rs1), .pcpi_rs2_i(pcpi_rs2),
		.pcpi_wr_o(pcpi_wr), .pcpi_rd_o(pcpi_rd), .pcpi_wait_o(pcpi_wait),
		.pcpi_ready_o(pcpi_ready), .pcpi_is_rvv_insn_o(pcpi_is_rvv),
		.mem_valid_o(mem_valid), .mem_write_o(mem_write), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_strb_o(mem_strb),
		.mem_rdata_i(mem_rdata), .mem_done_i(mem_done),
		.value_errs_o(value_errs), .proto_errs_o(proto_errs)
	);

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [31:0] stim_rand();
		stim_state = lcg(stim_state);
		return stim_state >> 8;   // low bits of an LCG are weak
	endfunction

	function automatic logic [31:0] enc_vsetvli(input logic [4:0] rd, rs1f, input logic [7:0] vt);
		return {1'b0, 3'b000, vt, rs1f, FUNCT3_CFG, rd, OPC_VEC_CFG};
	endfunction

	function automatic logic [31:0] enc_vsetivli(input logic [4:0] rd, uimm, input logic [7:0] vt);
		return {2'b11, 2'b00, vt, uimm, FUNCT3_CFG, rd, OPC_VEC_CFG};
	endfunction

	function automatic logic [31:0] enc_vsetvl(input logic [4:0] rd, rs1f);
		return {7'b1000000, 5'd2, rs1f, FUNCT3_CFG, rd, OPC_VEC_CFG};
	endfunction

	function automatic logic [31:0] enc_mem(input logic store, input logic [4:0] vd);
		return {12'h020, 5'd10, WIDTH_E32, vd, store ? OPC_VSTORE : OPC_VLOAD};
	endfunction

	// random vtype, mostly legal, sometimes e64 or fractional lmul
	function automatic logic [7:0] rand_vtype();
		logic [31:0] r;
		logic [2:0]  lmul;
		r = stim_rand();
		lmul = (r[3:0] < 4'd12) ? {1'b0, r[5:4]} : 3'd5 + 3'(r[7:6] % 3);
		return {r[11:10], r[9:8] == 2'b11 && r[12] ? 3'd2 : {1'b0, r[9:8]}, lmul};
	endfunction

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// hold the instruction until ready, drop valid in the ready cycle
	task automatic issue(input logic [31:0] insn, rs1, rs2);
		@(negedge clk);
		pcpi_valid = 1'b1;
		pcpi_insn  = insn;
		pcpi_rs1   = rs1;
		pcpi_rs2   = rs2;
		do @(negedge clk); while (!pcpi_ready);
		pcpi_valid = 1'b0;
	endtask

	task automatic present_only(input logic [31:0] insn);
		@(negedge clk);
		pcpi_insn = insn;
	endtask

	function automatic logic [31:0] rand_base();
		return (stim_rand() % (MEM_WORDS - MAX_VL)) * 4;
	endfunction

	// memory responder, 0..5 cycles of delay per transfer
	always @(negedge clk) begin
		if (!resetn) begin
			mem_done  = 1'b0;
			resp_busy = 1'b0;
		end else if (mem_done) begin
			mem_done  = 1'b0;
			resp_busy = 1'b0;
		end else if (mem_valid) begin
			if (!resp_busy) begin
				resp_state = lcg(resp_state);
				resp_delay = (resp_state >> 8) % 6;
				resp_busy  = 1'b1;
			end
			if (resp_delay == 0) begin
				mem_done  = 1'b1;
				mem_rdata = mem[mem_addr[11:2]];
				if (mem_write)
					mem[mem_addr[11:2]] = mem_wdata;
			end else begin
				resp_delay--;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYC_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, an instruction never completed", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		int          issued;
		logic [31:0] r;
		logic [4:0]  vd;
		logic [31:0] base;
		stim_state = SEED;
		resp_state = SEED ^ 32'h5a5a5a5a;
		resetn = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn = '0;
		pcpi_rs1 = '0;
		pcpi_rs2 = '0;
		mem_done = 1'b0;
		mem_rdata = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = stim_rand() ^ (i << 20);
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		present_only(32'h003100b3);                 // add x1, x2, x3
		present_only({12'h020, 5'd10, 3'b000, 5'd3, OPC_VLOAD});   // vle8
		present_only({12'h000, 5'd10, WIDTH_E32, 5'd3, OPC_VLOAD}); // vm=0
		// e32 m8, vl = 32, then fill all 32 registers
		issue(enc_vsetvli(5'd1, 5'd0, 8'h13), '0, '0);
		for (int g = 0; g < 4; g++)
			issue(enc_mem(1'b0, 5'(g * 8)), rand_base(), '0);
		// tail undisturbed: short load, longer store
		issue(enc_vsetivli(5'd1, 5'd2, 8'h11), '0, '0);
		issue(enc_mem(1'b0, 5'd4), rand_base(), '0);
		issue(enc_vsetivli(5'd1, 5'd8, 8'h11), '0, '0);
		issue(enc_mem(1'b1, 5'd4), rand_base(), '0);
		issued = 9;
		while (issued < N_INSN) begin
			r  = stim_rand();
			vd = 5'(stim_rand());
			case (r % 6)
				0: issue(enc_vsetvli(r[8] ? 5'd1 : 5'd0, r[9] ? 5'd5 : 5'd0, rand_vtype()),
					stim_rand() % 48, '0);
				1: issue(enc_vsetivli(r[8] ? 5'd1 : 5'd0, 5'(r[20:16]), rand_vtype()), '0, '0);
				2: issue(enc_vsetvl(r[8] ? 5'd1 : 5'd0, r[9] ? 5'd5 : 5'd0),
					stim_rand() % 48, {r[10], 23'd0, rand_vtype()});
				3: issue(enc_mem(1'b0, vd), rand_base(), '0);
				4: issue(enc_mem(1'b1, vd), rand_base(), '0);
				default: begin
					base = rand_base();
					issue(enc_mem(1'b0, vd), base, '0);
					issue(enc_mem(1'b1, vd), rand_base(), '0);
					issued++;
				end
			endcase
			issued++;
		end
		repeat (4) @(negedge clk);
		$display("errors: %0d value, %0d protocol", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
hdl/rvv_pkg.sv
hdl/rvv_decode.sv
hdl/rvv_vcfg.sv
hdl/rvv_mem_seq.sv
hdl/rvv_vregs.sv
hdl/rvv_coproc.sv
test/rvv_checker.sv
test/tb_rvv.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_rvv
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
